//--- sources.f
+incdir+verification
design/wb_dbus_pkg.sv
design/wb_master_select.sv
design/wb_slave_decode.sv
design/wb_slave_route.sv
design/wb_dbus_arbiter.sv
verification/tb_wb_dbus.sv

//--- run.sh
#!/bin/sh
# Build and run the arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_wb_dbus -o sim_tb_wb_dbus
status=$?
if [ $status -ne 0 ]; then
   echo "Compile step returned status $status"
   exit $status
fi

./obj_dir/sim_tb_wb_dbus
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation returned status $status"
   exit $status
fi

exit 0

//--- verification/tb_wb_dbus_tasks.svh
// Stop at the first error
task automatic report_fail(input string msg);
   $display("%s", msg);
   $display("Verification failed");
   $fatal(1, "Simulation stopped on error");
endtask

task automatic check_dat(input dat_t exp, input dat_t act);
   if (exp !== act) begin
      report_fail($sformatf("Error in %s: expected 0x%08h, actual 0x%08h",
                            test_name, exp, act));
   end
endtask

task automatic check_slv(input slv_vec_t exp, input slv_vec_t act);
   if (exp !== act) begin
      report_fail($sformatf("Error in %s: expected %b, actual %b",
                            test_name, exp, act));
   end
endtask

task automatic check_sel(input sel_t exp, input sel_t act);
   if (exp !== act) begin
      report_fail($sformatf("Error in %s: expected sel %b, actual %b",
                            test_name, exp, act));
   end
endtask

task automatic check_cti(input cti_t exp, input cti_t act);
   if (exp !== act) begin
      report_fail($sformatf("Error in %s: expected cti %b, actual %b",
                            test_name, exp, act));
   end
endtask

task automatic check_bte(input bte_t exp, input bte_t act);
   if (exp !== act) begin
      report_fail($sformatf("Error in %s: expected bte %b, actual %b",
                            test_name, exp, act));
   end
endtask

task automatic check_bit(input logic exp, input logic act);
   if (exp !== act) begin
      report_fail($sformatf("Error in %s: expected %b, actual %b",
                            test_name, exp, act));
   end
endtask

// Decode rule, RAM before DDR before peripheral
function automatic int expected_slave(input adr_t a);
   if (a[31:RAM_W] == '0) begin
      return SLV_RAM;
   end else if (a[31:DDR_W] == '0) begin
      return SLV_DDR;
   end else if (a[31:24] == PERIPH) begin
      return SLV_PERIPH;
   end
   return SLV_BYTE;
endfunction

function automatic dat_t read_pattern(input int k, input adr_t a);
   return {8'(k), a[23:0]};
endfunction

function automatic dat_t byte_mask(input sel_t s);
   return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
endfunction

//--- verification/tb_wb_dbus.sv
`timescale 1ns/1ps

module tb_wb_dbus
   import wb_dbus_pkg::*;
;

   localparam int DDR_W = 28;
   localparam int RAM_W = 24;
   localparam logic [7:0] PERIPH = 8'h92;
   localparam int TIMEOUT = 50;

   logic     wb_clk;
   logic     wb_rst;
   adr_t     m_adr [2];
   dat_t     m_dat [2];
   sel_t     m_sel [2];
   logic     m_we [2];
   logic     m_cyc [2];
   logic     m_stb [2];
   cti_t     m_cti [2];
   bte_t     m_bte [2];
   dat_t     wbm0_dat_o;
   dat_t     wbm1_dat_o;
   logic     wbm0_ack_o;
   logic     wbm0_err_o;
   logic     wbm0_rty_o;
   logic     wbm1_ack_o;
   logic     wbm1_err_o;
   logic     wbm1_rty_o;
   adr_t     wbs_adr_o;
   dat_t     wbs_dat_o;
   sel_t     wbs_sel_o;
   logic     wbs_we_o;
   cti_t     wbs_cti_o;
   bte_t     wbs_bte_o;
   slv_vec_t wbs_cyc_o;
   slv_vec_t wbs_stb_o;
   dat_t     wbs_dat_i [NUM_SLAVES];
   slv_vec_t wbs_ack_i;
   slv_vec_t wbs_err_i;
   slv_vec_t wbs_rty_i;
   string    test_name;
   integer   seed;

   `include "tb_wb_dbus_tasks.svh"

   wb_dbus_arbiter #(
      .DDR_ADR_WIDTH (DDR_W),
      .RAM_ADR_WIDTH (RAM_W),
      .MATCH_WIDTH   (8),
      .PERIPH_ADR    (PERIPH)
   ) i_dut (
      .wb_clk (wb_clk), .wb_rst (wb_rst),
      .wbm0_adr_i (m_adr[0]), .wbm0_dat_i (m_dat[0]), .wbm0_sel_i (m_sel[0]),
      .wbm0_we_i (m_we[0]), .wbm0_cyc_i (m_cyc[0]), .wbm0_stb_i (m_stb[0]),
      .wbm0_cti_i (m_cti[0]), .wbm0_bte_i (m_bte[0]),
      .wbm0_dat_o (wbm0_dat_o), .wbm0_ack_o (wbm0_ack_o),
      .wbm0_err_o (wbm0_err_o), .wbm0_rty_o (wbm0_rty_o),
      .wbm1_adr_i (m_adr[1]), .wbm1_dat_i (m_dat[1]), .wbm1_sel_i (m_sel[1]),
      .wbm1_we_i (m_we[1]), .wbm1_cyc_i (m_cyc[1]), .wbm1_stb_i (m_stb[1]),
      .wbm1_cti_i (m_cti[1]), .wbm1_bte_i (m_bte[1]),
      .wbm1_dat_o (wbm1_dat_o), .wbm1_ack_o (wbm1_ack_o),
      .wbm1_err_o (wbm1_err_o), .wbm1_rty_o (wbm1_rty_o),
      .wbs_adr_o (wbs_adr_o), .wbs_dat_o (wbs_dat_o), .wbs_sel_o (wbs_sel_o),
      .wbs_we_o (wbs_we_o), .wbs_cti_o (wbs_cti_o), .wbs_bte_o (wbs_bte_o),
      .wbs_cyc_o (wbs_cyc_o), .wbs_stb_o (wbs_stb_o), .wbs_dat_i (wbs_dat_i),
      .wbs_ack_i (wbs_ack_i), .wbs_err_i (wbs_err_i), .wbs_rty_i (wbs_rty_i)
   );

   initial begin
      wb_clk = 1'b0;
      forever #50 wb_clk = ~wb_clk;
   end

   assign wbs_rty_i = '0;

   // Slave k answers after k+1 cycles
   for (genvar k = 0; k < NUM_SLAVES; k++) begin : g_slave
      dat_t mem [16];
      logic [15:0] written;
      int cnt;
      logic resp;
      logic bad_ofs;

      assign bad_ofs = (k == SLV_PERIPH) && (wbs_adr_o[7:0] == 8'hFC);
      assign wbs_ack_i[k] = resp & ~bad_ofs;
      assign wbs_err_i[k] = resp & bad_ofs;
      assign wbs_dat_i[k] = written[wbs_adr_o[5:2]] ? mem[wbs_adr_o[5:2]]
                                                    : read_pattern(k, wbs_adr_o);

      always @(posedge wb_clk) begin
         if (wb_rst) begin
            written <= '0;
            cnt <= 0;
            resp <= 1'b0;
            for (int i = 0; i < 16; i++) begin
               mem[i] <= '0;
            end
         end else if (!(wbs_cyc_o[k] && wbs_stb_o[k]) || resp) begin
            cnt <= 0;
            resp <= 1'b0;
         end else if (cnt == k) begin
            resp <= 1'b1;
            if (wbs_we_o && !bad_ofs) begin
               mem[wbs_adr_o[5:2]] <= (mem[wbs_adr_o[5:2]] & ~byte_mask(wbs_sel_o))
                                      | (wbs_dat_o & byte_mask(wbs_sel_o));
               written[wbs_adr_o[5:2]] <= 1'b1;
            end
         end else begin
            cnt <= cnt + 1;
         end
      end
   end

   // One transfer from master m, address set up a cycle before cyc
   task automatic xfer(input int m, input adr_t a, input logic we, input dat_t wd,
                       input sel_t s, input logic chk_bus,
                       output dat_t rd, output logic got_err);
      int n;
      logic ack;
      logic err;
      cti_t c;
      bte_t b;
      slv_vec_t exp_sel;
      exp_sel = slv_vec_t'(1) << expected_slave(a);
      c = cti_t'($random(seed));
      b = bte_t'($random(seed));
      @(posedge wb_clk);
      m_adr[m] <= a;
      m_dat[m] <= wd;
      m_sel[m] <= s;
      m_we[m]  <= we;
      m_cti[m] <= c;
      m_bte[m] <= b;
      @(posedge wb_clk);
      m_cyc[m] <= 1'b1;
      m_stb[m] <= 1'b1;
      n = 0;
      ack = 1'b0;
      err = 1'b0;
      while (!ack && !err) begin
         @(negedge wb_clk);
         ack = (m == 0) ? wbm0_ack_o : wbm1_ack_o;
         err = (m == 0) ? wbm0_err_o : wbm1_err_o;
         if (m == 0 && m_cyc[1] && (wbm0_ack_o || wbm0_err_o)) begin
            report_fail("CPU master got a response while the debug master held cyc");
         end
         if (chk_bus) begin
            check_slv(exp_sel, wbs_cyc_o);
            check_slv(exp_sel, wbs_stb_o);
            check_sel(s, wbs_sel_o);
            check_bit(we, wbs_we_o);
            check_cti(c, wbs_cti_o);
            check_bte(b, wbs_bte_o);
         end
         n++;
         if (n > TIMEOUT) begin
            report_fail($sformatf("Timeout waiting for a response in %s", test_name));
         end
      end
      rd = (m == 0) ? wbm0_dat_o : wbm1_dat_o;
      got_err = err;
      @(posedge wb_clk);
      m_cyc[m] <= 1'b0;
      m_stb[m] <= 1'b0;
      m_we[m]  <= 1'b0;
   endtask

   task automatic test_reset_idle();
      test_name = "reset_idle";
      @(negedge wb_clk);
      check_slv('0, wbs_cyc_o);
      check_slv('0, wbs_stb_o);
      check_bit(1'b0, wbm0_ack_o | wbm0_err_o | wbm0_rty_o);
      check_bit(1'b0, wbm1_ack_o | wbm1_err_o | wbm1_rty_o);
   endtask

   task automatic test_decode(input adr_t a);
      dat_t rd;
      logic e;
      test_name = $sformatf("decode_%08h", a);
      xfer(0, a, 1'b0, '0, 4'hF, 1'b1, rd, e);
      check_bit(1'b0, e);
      check_dat(read_pattern(expected_slave(a), a), rd);
   endtask

   task automatic test_write_read(input adr_t a, input dat_t wd, input sel_t s);
      dat_t rd;
      logic e;
      test_name = $sformatf("write_read_%08h", a);
      xfer(0, a, 1'b1, wd, s, 1'b1, rd, e);
      check_bit(1'b0, e);
      xfer(0, a, 1'b0, '0, 4'hF, 1'b1, rd, e);
      check_bit(1'b0, e);
      check_dat(wd & byte_mask(s), rd);
   endtask

   task automatic test_priority();
      dat_t rd0;
      dat_t rd1;
      logic e0;
      logic e1;
      logic dbg_done;
      logic cpu_early;
      adr_t a0;
      adr_t a1;
      test_name = "priority";
      a0 = 32'h0000_0450;
      a1 = 32'h0000_0860;
      dbg_done = 1'b0;
      cpu_early = 1'b0;
      fork
         begin
            xfer(1, a1, 1'b0, '0, 4'hF, 1'b1, rd1, e1);
            dbg_done = 1'b1;
         end
         begin
            xfer(0, a0, 1'b0, '0, 4'hF, 1'b0, rd0, e0);
            cpu_early = ~dbg_done;
         end
      join
      check_bit(1'b0, cpu_early);
      check_dat(read_pattern(SLV_RAM, a1), rd1);
      check_dat(read_pattern(SLV_RAM, a0), rd0);
   endtask

   task automatic test_err(input int m);
      dat_t rd;
      logic e;
      adr_t a;
      int n;
      test_name = $sformatf("err_master%0d", m);
      a = {PERIPH, 24'h0001FC};
      fork
         xfer(m, a, 1'b0, '0, 4'hF, 1'b0, rd, e);
         begin
            // Other master must stay quiet for the whole transfer
            for (n = 0; n < 6; n++) begin
               @(negedge wb_clk);
               check_bit(1'b0, (m == 0) ? wbm1_err_o : wbm0_err_o);
               check_bit(1'b0, wbm0_ack_o | wbm1_ack_o);
            end
         end
      join
      check_bit(1'b1, e);
   endtask

   initial begin
      adr_t byte_adr;
      seed = 73;
      wb_rst <= 1'b1;
      for (int i = 0; i < 2; i++) begin
         m_adr[i] <= '0;
         m_dat[i] <= '0;
         m_sel[i] <= '0;
         m_we[i]  <= 1'b0;
         m_cyc[i] <= 1'b0;
         m_stb[i] <= 1'b0;
         m_cti[i] <= '0;
         m_bte[i] <= '0;
      end
      repeat (8) @(posedge wb_clk);
      wb_rst <= 1'b0;

      test_reset_idle();

      byte_adr = adr_t'($random(seed));
      byte_adr[31] = 1'b1;
      if (byte_adr[31:24] == PERIPH) begin
         byte_adr[24] = ~byte_adr[24];
      end
      test_decode(32'h0123_4560);
      test_decode(32'h0000_1230);
      test_decode(32'h9200_0040);
      test_decode(byte_adr);

      test_write_read(32'h0123_4564, 32'hA5A5_1234, 4'hF);
      test_write_read(32'h0000_0018, dat_t'($random(seed)), 4'hF);
      test_write_read(32'h9200_0028, 32'hDEAD_BEEF, 4'h3);
      test_write_read({byte_adr[31:6], 6'h0C}, 32'h7777_0001, 4'hC);

      test_priority();
      test_err(0);
      test_err(1);

      $display("Verification passed");
      $finish;
   end

endmodule

//--- design/wb_dbus_arbiter.sv
`timescale 1ns/1ps

module wb_dbus_arbiter
   import wb_dbus_pkg::*;
#(
   parameter int DDR_ADR_WIDTH = 28,
   parameter int RAM_ADR_WIDTH = 24,
   parameter int MATCH_WIDTH = 8,
   parameter logic [MATCH_WIDTH-1:0] PERIPH_ADR = 8'h92
)
(
   input  logic     wb_clk,
   input  logic     wb_rst,

   // CPU data master
   input  adr_t     wbm0_adr_i,
   input  dat_t     wbm0_dat_i,
   input  sel_t     wbm0_sel_i,
   input  logic     wbm0_we_i,
   input  logic     wbm0_cyc_i,
   input  logic     wbm0_stb_i,
   input  cti_t     wbm0_cti_i,
   input  bte_t     wbm0_bte_i,
   output dat_t     wbm0_dat_o,
   output logic     wbm0_ack_o,
   output logic     wbm0_err_o,
   output logic     wbm0_rty_o,

   // Debug master
   input  adr_t     wbm1_adr_i,
   input  dat_t     wbm1_dat_i,
   input  sel_t     wbm1_sel_i,
   input  logic     wbm1_we_i,
   input  logic     wbm1_cyc_i,
   input  logic     wbm1_stb_i,
   input  cti_t     wbm1_cti_i,
   input  bte_t     wbm1_bte_i,
   output dat_t     wbm1_dat_o,
   output logic     wbm1_ack_o,
   output logic     wbm1_err_o,
   output logic     wbm1_rty_o,

   // Slave side
   output adr_t     wbs_adr_o,
   output dat_t     wbs_dat_o,
   output sel_t     wbs_sel_o,
   output logic     wbs_we_o,
   output cti_t     wbs_cti_o,
   output bte_t     wbs_bte_o,
   output slv_vec_t wbs_cyc_o,
   output slv_vec_t wbs_stb_o,
   input  dat_t     wbs_dat_i [NUM_SLAVES],
   input  slv_vec_t wbs_ack_i,
   input  slv_vec_t wbs_err_i,
   input  slv_vec_t wbs_rty_i
);

   // Granted master request
   adr_t     bus_adr;
   dat_t     bus_dat;
   sel_t     bus_sel;
   logic     bus_we;
   logic     bus_cyc;
   logic     bus_stb;
   cti_t     bus_cti;
   bte_t     bus_bte;

   // Selected slave response
   dat_t     bus_dat_r;
   logic     bus_ack;
   logic     bus_err;
   logic     bus_rty;

   slv_vec_t slave_sel;

   wb_master_select u_master_select (
      .wbm0_adr_i (wbm0_adr_i),
      .wbm0_dat_i (wbm0_dat_i),
      .wbm0_sel_i (wbm0_sel_i),
      .wbm0_we_i  (wbm0_we_i),
      .wbm0_cyc_i (wbm0_cyc_i),
      .wbm0_stb_i (wbm0_stb_i),
      .wbm0_cti_i (wbm0_cti_i),
      .wbm0_bte_i (wbm0_bte_i),
      .wbm0_dat_o (wbm0_dat_o),
      .wbm0_ack_o (wbm0_ack_o),
      .wbm0_err_o (wbm0_err_o),
      .wbm0_rty_o (wbm0_rty_o),
      .wbm1_adr_i (wbm1_adr_i),
      .wbm1_dat_i (wbm1_dat_i),
      .wbm1_sel_i (wbm1_sel_i),
      .wbm1_we_i  (wbm1_we_i),
      .wbm1_cyc_i (wbm1_cyc_i),
      .wbm1_stb_i (wbm1_stb_i),
      .wbm1_cti_i (wbm1_cti_i),
      .wbm1_bte_i (wbm1_bte_i),
      .wbm1_dat_o (wbm1_dat_o),
      .wbm1_ack_o (wbm1_ack_o),
      .wbm1_err_o (wbm1_err_o),
      .wbm1_rty_o (wbm1_rty_o),
      .bus_adr_o  (bus_adr),
      .bus_dat_o  (bus_dat),
      .bus_sel_o  (bus_sel),
      .bus_we_o   (bus_we),
      .bus_cyc_o  (bus_cyc),
      .bus_stb_o  (bus_stb),
      .bus_cti_o  (bus_cti),
      .bus_bte_o  (bus_bte),
      .bus_dat_i  (bus_dat_r),
      .bus_ack_i  (bus_ack),
      .bus_err_i  (bus_err),
      .bus_rty_i  (bus_rty)
   );

   wb_slave_decode #(
      .DDR_ADR_WIDTH (DDR_ADR_WIDTH),
      .RAM_ADR_WIDTH (RAM_ADR_WIDTH),
      .MATCH_WIDTH   (MATCH_WIDTH),
      .PERIPH_ADR    (PERIPH_ADR)
   ) u_slave_decode (
      .wb_clk      (wb_clk),
      .wb_rst      (wb_rst),
      .bus_adr_i   (bus_adr),
      .slave_sel_o (slave_sel)
   );

   wb_slave_route u_slave_route (
      .slave_sel_i (slave_sel),
      .bus_adr_i   (bus_adr),
      .bus_dat_i   (bus_dat),
      .bus_sel_i   (bus_sel),
      .bus_we_i    (bus_we),
      .bus_cyc_i   (bus_cyc),
      .bus_stb_i   (bus_stb),
      .bus_cti_i   (bus_cti),
      .bus_bte_i   (bus_bte),
      .wbs_adr_o   (wbs_adr_o),
      .wbs_dat_o   (wbs_dat_o),
      .wbs_sel_o   (wbs_sel_o),
      .wbs_we_o    (wbs_we_o),
      .wbs_cti_o   (wbs_cti_o),
      .wbs_bte_o   (wbs_bte_o),
      .wbs_cyc_o   (wbs_cyc_o),
      .wbs_stb_o   (wbs_stb_o),
      .wbs_dat_i   (wbs_dat_i),
      .wbs_ack_i   (wbs_ack_i),
      .wbs_err_i   (wbs_err_i),
      .wbs_rty_i   (wbs_rty_i),
      .bus_dat_o   (bus_dat_r),
      .bus_ack_o   (bus_ack),
      .bus_err_o   (bus_err),
      .bus_rty_o   (bus_rty)
   );

endmodule

//--- design/wb_slave_route.sv
`timescale 1ns/1ps

module wb_slave_route
   import wb_dbus_pkg::*;
(
   input  slv_vec_t slave_sel_i,

   // Request from the granted master
   input  adr_t     bus_adr_i,
   input  dat_t     bus_dat_i,
   input  sel_t     bus_sel_i,
   input  logic     bus_we_i,
   input  logic     bus_cyc_i,
   input  logic     bus_stb_i,
   input  cti_t     bus_cti_i,
   input  bte_t     bus_bte_i,

   // Shared slave request lines
   output adr_t     wbs_adr_o,
   output dat_t     wbs_dat_o,
   output sel_t     wbs_sel_o,
   output logic     wbs_we_o,
   output cti_t     wbs_cti_o,
   output bte_t     wbs_bte_o,

   // Per-slave strobes
   output slv_vec_t wbs_cyc_o,
   output slv_vec_t wbs_stb_o,

   // Slave responses
   input  dat_t     wbs_dat_i [NUM_SLAVES],
   input  slv_vec_t wbs_ack_i,
   input  slv_vec_t wbs_err_i,
   input  slv_vec_t wbs_rty_i,

   // Combined response back to the master side
   output dat_t     bus_dat_o,
   output logic     bus_ack_o,
   output logic     bus_err_o,
   output logic     bus_rty_o
);

   slv_vec_t ack_masked;
   slv_vec_t err_masked;
   slv_vec_t rty_masked;

   assign wbs_adr_o = bus_adr_i;
   assign wbs_dat_o = bus_dat_i;
   assign wbs_sel_o = bus_sel_i;
   assign wbs_we_o  = bus_we_i;
   assign wbs_cti_o = bus_cti_i;
   assign wbs_bte_o = bus_bte_i;

   // Only the selected slave sees the cycle
   assign wbs_cyc_o = {NUM_SLAVES{bus_cyc_i}} & slave_sel_i;
   assign wbs_stb_o = {NUM_SLAVES{bus_stb_i}} & slave_sel_i;

   // Ignore stray handshakes from slaves that are not selected
   assign ack_masked = wbs_ack_i & slave_sel_i;
   assign err_masked = wbs_err_i & slave_sel_i;
   assign rty_masked = wbs_rty_i & slave_sel_i;

   assign bus_ack_o = |ack_masked;
   assign bus_err_o = |err_masked;
   assign bus_rty_o = |rty_masked;

   // DDR data when the select is empty, as after reset
   always_comb begin
      bus_dat_o = wbs_dat_i[SLV_DDR];
      for (int i = 0; i < NUM_SLAVES; i++) begin
         if (slave_sel_i[i]) begin
            bus_dat_o = wbs_dat_i[i];
         end
      end
   end

endmodule

//--- design/wb_slave_decode.sv
`timescale 1ns/1ps

module wb_slave_decode
   import wb_dbus_pkg::*;
#(
   parameter int DDR_ADR_WIDTH = 28,
   parameter int RAM_ADR_WIDTH = 24,
   parameter int MATCH_WIDTH = 8,
   parameter logic [MATCH_WIDTH-1:0] PERIPH_ADR = 8'h92
)
(
   input  logic     wb_clk,
   input  logic     wb_rst,
   input  adr_t     bus_adr_i,
   output slv_vec_t slave_sel_o
);

   logic     ram_hit;
   logic     ddr_hit;
   logic     periph_hit;
   slv_vec_t sel_next;
   slv_vec_t sel_r;

   // Region tests on the upper address bits
   assign ram_hit    = ~|bus_adr_i[ADR_WIDTH-1:RAM_ADR_WIDTH];
   assign ddr_hit    = ~|bus_adr_i[ADR_WIDTH-1:DDR_ADR_WIDTH];
   assign periph_hit = bus_adr_i[ADR_WIDTH-1 -: MATCH_WIDTH] == PERIPH_ADR;

   // RAM sits inside the DDR window, so it is tested first
   always_comb begin
      sel_next = '0;
      if (ram_hit) begin
         sel_next[SLV_RAM] = 1'b1;
      end else if (ddr_hit) begin
         sel_next[SLV_DDR] = 1'b1;
      end else if (periph_hit) begin
         sel_next[SLV_PERIPH] = 1'b1;
      end else begin
         // Nothing else claimed it
         sel_next[SLV_BYTE] = 1'b1;
      end
   end

   // Registered so the default slave has no path back to the master
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         sel_r <= '0;
      end else begin
         sel_r <= sel_next;
      end
   end

   assign slave_sel_o = sel_r;

endmodule

//--- design/wb_master_select.sv
`timescale 1ns/1ps

module wb_master_select
   import wb_dbus_pkg::*;
(
   // CPU data master
   input  adr_t wbm0_adr_i,
   input  dat_t wbm0_dat_i,
   input  sel_t wbm0_sel_i,
   input  logic wbm0_we_i,
   input  logic wbm0_cyc_i,
   input  logic wbm0_stb_i,
   input  cti_t wbm0_cti_i,
   input  bte_t wbm0_bte_i,
   output dat_t wbm0_dat_o,
   output logic wbm0_ack_o,
   output logic wbm0_err_o,
   output logic wbm0_rty_o,

   // Debug master
   input  adr_t wbm1_adr_i,
   input  dat_t wbm1_dat_i,
   input  sel_t wbm1_sel_i,
   input  logic wbm1_we_i,
   input  logic wbm1_cyc_i,
   input  logic wbm1_stb_i,
   input  cti_t wbm1_cti_i,
   input  bte_t wbm1_bte_i,
   output dat_t wbm1_dat_o,
   output logic wbm1_ack_o,
   output logic wbm1_err_o,
   output logic wbm1_rty_o,

   // Shared request towards the slave side
   output adr_t bus_adr_o,
   output dat_t bus_dat_o,
   output sel_t bus_sel_o,
   output logic bus_we_o,
   output logic bus_cyc_o,
   output logic bus_stb_o,
   output cti_t bus_cti_o,
   output bte_t bus_bte_o,

   // Response from the selected slave
   input  dat_t bus_dat_i,
   input  logic bus_ack_i,
   input  logic bus_err_i,
   input  logic bus_rty_i
);

   logic cpu_grant;
   logic dbg_grant;

   // Debug port wins whenever it holds cyc
   assign dbg_grant = wbm1_cyc_i;
   assign cpu_grant = wbm0_cyc_i & ~wbm1_cyc_i;

   assign bus_adr_o = dbg_grant ? wbm1_adr_i : wbm0_adr_i;
   assign bus_dat_o = dbg_grant ? wbm1_dat_i : wbm0_dat_i;
   assign bus_sel_o = dbg_grant ? wbm1_sel_i : wbm0_sel_i;
   assign bus_we_o  = dbg_grant ? wbm1_we_i  : wbm0_we_i;
   assign bus_cyc_o = dbg_grant ? wbm1_cyc_i : wbm0_cyc_i;
   assign bus_stb_o = dbg_grant ? wbm1_stb_i : wbm0_stb_i;
   assign bus_cti_o = dbg_grant ? wbm1_cti_i : wbm0_cti_i;
   assign bus_bte_o = dbg_grant ? wbm1_bte_i : wbm0_bte_i;

   // Read data goes to both, handshakes only to the owner
   assign wbm0_dat_o = bus_dat_i;
   assign wbm0_ack_o = bus_ack_i & cpu_grant;
   assign wbm0_err_o = bus_err_i & cpu_grant;
   assign wbm0_rty_o = bus_rty_i & cpu_grant;

   assign wbm1_dat_o = bus_dat_i;
   assign wbm1_ack_o = bus_ack_i & dbg_grant;
   assign wbm1_err_o = bus_err_i & dbg_grant;
   assign wbm1_rty_o = bus_rty_i & dbg_grant;

endmodule

//--- design/wb_dbus_pkg.sv
package wb_dbus_pkg;

   // Bus widths
   localparam int ADR_WIDTH = 32;
   localparam int DAT_WIDTH = 32;
   localparam int SEL_WIDTH = DAT_WIDTH / 8;

   typedef logic [ADR_WIDTH-1:0] adr_t;
   typedef logic [DAT_WIDTH-1:0] dat_t;
   typedef logic [SEL_WIDTH-1:0] sel_t;

   // Wishbone registered feedback cycle and burst type
   typedef logic [2:0] cti_t;
   typedef logic [1:0] bte_t;

   localparam int NUM_SLAVES = 4;

   // One bit per slave, select and handshakes
   typedef logic [NUM_SLAVES-1:0] slv_vec_t;

   // Slave positions in slv_vec_t and in the read data array
   localparam int SLV_DDR    = 0;
   localparam int SLV_PERIPH = 1;
   localparam int SLV_BYTE   = 2;
   localparam int SLV_RAM    = 3;

endpackage
